// File: include/frogger_consts.svh
`ifndef FROGGER_CONSTS_SVH
`define FROGGER_CONSTS_SVH

// 640x480 VGA timing
`define H_VISIBLE_AREA   640
`define H_FRONT_PORCH    16
`define H_SYNC_PULSE     96
`define H_TOTAL          800
`define V_VISIBLE_AREA   480
`define V_FRONT_PORCH    10
`define V_SYNC_PULSE     2
`define V_TOTAL          525

`define TILE_SIZE        32
`define FROG_X_BASE      320
`define FROG_Y_BASE      448

// Tile rows holding cars
`define LANE_ROW_0       3
`define LANE_ROW_1       5
`define LANE_ROW_2       7
`define LANE_ROW_3       9

`define DEBOUNCE_LIMIT   250000
`define CAR_BASE_SPEED   1
`define LFSR_BITS        8

`endif

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // Current beam position from the timing generator
    typedef struct packed {
        logic [9:0] hCount;
        logic [9:0] vCount;
        logic       visible;
    } scan_pos_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;
    } vga_pixel_t;

endpackage

`default_nettype wire

// File: verilog/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic {IDLE, RUNNING} game_state_e;

    typedef enum logic [1:0] {UP, LEFT, RIGHT, DOWN} frog_dir_e;

    // Debounced switch levels
    typedef struct packed {
        logic up;
        logic left;
        logic right;
        logic down;
    } switches_t;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } frog_pos_t;

    typedef logic [3:0][9:0] car_lanes_t;  // Left edge of each car

endpackage

`default_nettype wire

// File: verilog/debounce_filter.sv
`timescale 1ns/1ps
`default_nettype none

module debounce_filter #(
    parameter int DebounceLimit = 10
) (
    input  logic i_Clk,
    input  logic i_rst,
    input  logic i_Switch,
    output logic o_Switch
);

    localparam int CountBits = $clog2(DebounceLimit + 1);

    logic [CountBits-1:0] count;

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            count    <= '0;
            o_Switch <= 1'b0;
        end
        else if (i_Switch != o_Switch)
        begin
            if (count == CountBits'(DebounceLimit - 1))  // Stable long enough
            begin
                o_Switch <= i_Switch;
                count    <= '0;
            end
            else
            begin
                count <= count + 1'b1;
            end
        end
        else
        begin
            count <= '0;  // Bounce restarts the wait
        end
    end

    // Output may only move on the last step of a full stable run
    assert property (@(posedge i_Clk) disable iff (i_rst)
        $changed(o_Switch) |-> $past(count) == CountBits'(DebounceLimit - 1))
    else $error("debounce output changed early");

endmodule

`default_nettype wire

// File: verilog/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module vga_timing import video_pkg::*; (
    input  logic      i_Clk,
    input  logic      i_rst,
    output scan_pos_t o_Scan,
    output logic      o_HSync,
    output logic      o_VSync,
    output logic      o_Frame_Start
);

    localparam int HSyncStart = `H_VISIBLE_AREA + `H_FRONT_PORCH;
    localparam int HSyncEnd   = HSyncStart + `H_SYNC_PULSE;
    localparam int VSyncStart = `V_VISIBLE_AREA + `V_FRONT_PORCH;
    localparam int VSyncEnd   = VSyncStart + `V_SYNC_PULSE;

    logic [9:0] hCount;
    logic [9:0] vCount;

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            hCount  <= '0;
            vCount  <= '0;
            o_HSync <= 1'b1;
            o_VSync <= 1'b1;
        end
        else
        begin
            if (hCount == 10'(`H_TOTAL - 1))
            begin
                hCount <= '0;
                vCount <= (vCount == 10'(`V_TOTAL - 1)) ? '0 : vCount + 1'b1;
            end
            else
            begin
                hCount <= hCount + 1'b1;
            end
            // Active low pulses
            o_HSync <= !(hCount >= 10'(HSyncStart) && hCount < 10'(HSyncEnd));
            o_VSync <= !(vCount >= 10'(VSyncStart) && vCount < 10'(VSyncEnd));
        end
    end

    assign o_Scan = '{hCount:  hCount,
                      vCount:  vCount,
                      visible: (hCount < 10'(`H_VISIBLE_AREA)) && (vCount < 10'(`V_VISIBLE_AREA))};

    assign o_Frame_Start = (hCount == '0) && (vCount == '0);

    assert property (@(posedge i_Clk) disable iff (i_rst)
        !o_HSync |-> ($past(hCount) >= 10'(HSyncStart)) && ($past(hCount) < 10'(HSyncEnd)))
    else $error("hsync low outside its window");

endmodule

`default_nettype wire

// File: verilog/frog_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module frog_control import game_pkg::*; (
    input  logic       i_Clk,
    input  logic       i_rst,
    input  logic       i_Game_Active,
    input  logic       i_Collided,
    input  switches_t  i_Switches,
    output frog_pos_t  o_Frog,
    output frog_dir_e  o_Dir,
    output logic [3:0] o_Score,
    output logic       o_Level_Up
);

    localparam logic [9:0] XBase = 10'(`FROG_X_BASE);
    localparam logic [8:0] YBase = 9'(`FROG_Y_BASE);
    localparam logic [9:0] XMax  = 10'(`H_VISIBLE_AREA - `TILE_SIZE);
    localparam logic [8:0] YMax  = 9'(`V_VISIBLE_AREA - `TILE_SIZE);
    localparam logic [9:0] TileX = 10'(`TILE_SIZE);
    localparam logic [8:0] TileY = 9'(`TILE_SIZE);

    switches_t  switchPrev;
    logic [3:0] pressed;  // up, left, right, down

    assign pressed = i_Switches & ~switchPrev;

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            switchPrev <= '0;
            o_Frog     <= '{x: XBase, y: YBase};
            o_Dir      <= UP;
            o_Score    <= '0;
            o_Level_Up <= 1'b0;
        end
        else
        begin
            switchPrev <= i_Switches;
            o_Level_Up <= 1'b0;
            if (i_Collided)
            begin
                o_Frog  <= '{x: XBase, y: YBase};
                o_Score <= '0;
            end
            else if (o_Frog.y == '0)  // Made it across
            begin
                o_Frog     <= '{x: XBase, y: YBase};
                o_Score    <= (o_Score == 4'd9) ? 4'd9 : o_Score + 1'b1;
                o_Level_Up <= 1'b1;
            end
            else if (i_Game_Active)
            begin
                if (pressed[3])
                begin
                    o_Dir    <= UP;
                    o_Frog.y <= (o_Frog.y >= TileY) ? o_Frog.y - TileY : '0;
                end
                else if (pressed[2])
                begin
                    o_Dir    <= LEFT;
                    o_Frog.x <= (o_Frog.x >= TileX) ? o_Frog.x - TileX : '0;
                end
                else if (pressed[1])
                begin
                    o_Dir    <= RIGHT;
                    o_Frog.x <= (o_Frog.x < XMax) ? o_Frog.x + TileX : XMax;
                end
                else if (pressed[0])
                begin
                    o_Dir    <= DOWN;
                    o_Frog.y <= (o_Frog.y < YMax) ? o_Frog.y + TileY : YMax;
                end
            end
        end
    end

    assert property (@(posedge i_Clk) disable iff (i_rst) o_Score <= 4'd9)
    else $error("score above 9");

endmodule

`default_nettype wire

// File: verilog/traffic_lanes.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module traffic_lanes import game_pkg::*; (
    input  logic       i_Clk,
    input  logic       i_rst,
    input  logic       i_Frame_Start,
    input  logic       i_Level_Up,
    input  logic [3:0] i_Score,
    output car_lanes_t o_Cars
);

    localparam logic [`LFSR_BITS-1:0] LfsrSeed = `LFSR_BITS'(8'hA5);

    logic [`LFSR_BITS-1:0] lfsr;
    logic [`LFSR_BITS-1:0] lfsrNext;
    logic [3:0]            laneRight;  // One bit per lane, 1 moves right
    logic [9:0]            speed;

    function automatic logic [9:0] stepCar(input logic [9:0] x, input logic right,
                                           input logic [9:0] step);
        logic [10:0] sum;
        sum = {1'b0, x} + {1'b0, step};
        if (right)
            stepCar = (sum >= 11'(`H_VISIBLE_AREA)) ? 10'(sum - 11'(`H_VISIBLE_AREA)) : sum[9:0];
        else
            stepCar = (x < step) ? x + 10'(`H_VISIBLE_AREA) - step : x - step;
    endfunction

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsrNext = {lfsr[`LFSR_BITS-2:0], lfsr[`LFSR_BITS-1] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    assign speed = 10'(`CAR_BASE_SPEED) + 10'(i_Score / 4'd3);

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
            lfsr <= LfsrSeed;
        else
            lfsr <= (lfsrNext == '0) ? LfsrSeed : lfsrNext;  // Lock-up guard
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            laneRight <= LfsrSeed[3:0];
            o_Cars    <= {10'd480, 10'd320, 10'd160, 10'd0};
        end
        else
        begin
            if (i_Level_Up)
                laneRight <= lfsr[3:0];
            if (i_Frame_Start)
            begin
                for (int i = 0; i < 4; i++)
                    o_Cars[i] <= stepCar(o_Cars[i], laneRight[i], speed);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/collision_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module collision_check import game_pkg::*; (
    input  logic       i_Clk,
    input  logic       i_rst,
    input  frog_pos_t  i_Frog,
    input  car_lanes_t i_Cars,
    output logic       o_Collided
);

    localparam int LaneRow [4] = '{`LANE_ROW_0, `LANE_ROW_1, `LANE_ROW_2, `LANE_ROW_3};

    logic        hit;
    logic [10:0] frogLeft;
    logic [8:0]  frogRow;

    assign frogLeft = {1'b0, i_Frog.x};
    assign frogRow  = i_Frog.y / 9'(`TILE_SIZE);

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (frogRow == 9'(LaneRow[i])
                && frogLeft < {1'b0, i_Cars[i]} + 11'(`TILE_SIZE)
                && {1'b0, i_Cars[i]} < frogLeft + 11'(`TILE_SIZE))
                hit = 1'b1;
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
            o_Collided <= 1'b0;
        else
            o_Collided <= hit;
    end

endmodule

`default_nettype wire

// File: verilog/scene_renderer.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module scene_renderer import video_pkg::*, game_pkg::*; (
    input  logic       i_Clk,
    input  logic       i_rst,
    input  scan_pos_t  i_Scan,
    input  logic       i_HSync,
    input  logic       i_VSync,
    input  frog_pos_t  i_Frog,
    input  frog_dir_e  i_Dir,
    input  car_lanes_t i_Cars,
    output vga_pixel_t o_Pixel,
    output logic       o_HSync,
    output logic       o_VSync
);

    localparam int LaneRow [4] = '{`LANE_ROW_0, `LANE_ROW_1, `LANE_ROW_2, `LANE_ROW_3};
    localparam int TileBits    = $clog2(`TILE_SIZE);
    localparam int MarkWidth   = `TILE_SIZE / 4;

    localparam vga_pixel_t GoalColor  = '{red: 3'd0, green: 3'd2, blue: 3'd6};
    localparam vga_pixel_t GrassColor = '{red: 3'd0, green: 3'd5, blue: 3'd0};
    localparam vga_pixel_t RoadColor  = '{red: 3'd2, green: 3'd2, blue: 3'd2};
    localparam vga_pixel_t CarColor   = '{red: 3'd7, green: 3'd1, blue: 3'd0};
    localparam vga_pixel_t FrogColor  = '{red: 3'd1, green: 3'd7, blue: 3'd1};
    localparam vga_pixel_t MarkColor  = '{red: 3'd0, green: 3'd3, blue: 3'd0};

    logic [10:0]         hPos;
    logic [10:0]         vPos;
    logic [10:0]         frogX;
    logic [10:0]         frogY;
    logic [TileBits-1:0] dx;
    logic [TileBits-1:0] dy;
    logic [4:0]          tileRow;
    logic                inFrog;
    logic                inMarker;
    logic                inCar;
    vga_pixel_t          color;

    assign hPos    = {1'b0, i_Scan.hCount};
    assign vPos    = {1'b0, i_Scan.vCount};
    assign frogX   = {1'b0, i_Frog.x};
    assign frogY   = {2'b0, i_Frog.y};
    assign dx      = TileBits'(hPos - frogX);  // Offset inside the frog tile
    assign dy      = TileBits'(vPos - frogY);
    assign tileRow = 5'(i_Scan.vCount / 10'(`TILE_SIZE));

    assign inFrog = hPos >= frogX && hPos < frogX + 11'(`TILE_SIZE)
                 && vPos >= frogY && vPos < frogY + 11'(`TILE_SIZE);

    always_comb
    begin
        case (i_Dir)
            UP:      inMarker = dy < TileBits'(MarkWidth);
            LEFT:    inMarker = dx < TileBits'(MarkWidth);
            RIGHT:   inMarker = dx >= TileBits'(`TILE_SIZE - MarkWidth);
            default: inMarker = dy >= TileBits'(`TILE_SIZE - MarkWidth);
        endcase
    end

    always_comb
    begin
        inCar = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (tileRow == 5'(LaneRow[i])
                && hPos >= {1'b0, i_Cars[i]} && hPos < {1'b0, i_Cars[i]} + 11'(`TILE_SIZE))
                inCar = 1'b1;
        end
    end

    always_comb
    begin
        if (inFrog)
            color = inMarker ? MarkColor : FrogColor;
        else if (inCar)
            color = CarColor;
        else if (tileRow == '0)
            color = GoalColor;
        else if (tileRow >= 5'(LaneRow[0] - 1) && tileRow <= 5'(LaneRow[3] + 1))
            color = RoadColor;
        else
            color = GrassColor;
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            o_Pixel <= '0;
            o_HSync <= 1'b1;
            o_VSync <= 1'b1;
        end
        else
        begin
            o_Pixel <= i_Scan.visible ? color : '0;  // Black in blanking
            o_HSync <= i_HSync;
            o_VSync <= i_VSync;
        end
    end

endmodule

`default_nettype wire

// File: verilog/frogger_game.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module frogger_game import game_pkg::*, video_pkg::*; #(
    parameter int DebounceLimit = `DEBOUNCE_LIMIT
) (
    input  logic       i_Clk,
    input  logic       i_rst,
    input  logic       i_Switch_Up,
    input  logic       i_Switch_Left,
    input  logic       i_Switch_Right,
    input  logic       i_Switch_Down,
    output logic       o_VGA_HSync,
    output logic       o_VGA_VSync,
    output vga_pixel_t o_VGA_Pixel,
    output logic [6:0] o_Segments,  // A in bit 6, G in bit 0, active high
    output logic       o_Led_Active
);

    logic [3:0]  rawSwitch;
    logic [3:0]  filtered;
    switches_t   switches;
    logic        allSwitches;
    scan_pos_t   scan;
    logic        hSync;
    logic        vSync;
    logic        frameStart;
    frog_pos_t   frog;
    frog_dir_e   frogDir;
    logic [3:0]  score;
    logic        levelUp;
    car_lanes_t  cars;
    logic        collided;
    game_state_e state;

    assign rawSwitch   = {i_Switch_Up, i_Switch_Left, i_Switch_Right, i_Switch_Down};
    assign switches    = switches_t'(filtered);
    assign allSwitches = &filtered;

    for (genvar i = 0; i < 4; i++)
    begin : gen_debounce
        debounce_filter #(.DebounceLimit(DebounceLimit)) u_debounce (
            .i_Clk(i_Clk), .i_rst(i_rst), .i_Switch(rawSwitch[i]), .o_Switch(filtered[i]));
    end

    vga_timing u_timing (
        .i_Clk(i_Clk), .i_rst(i_rst), .o_Scan(scan),
        .o_HSync(hSync), .o_VSync(vSync), .o_Frame_Start(frameStart));

    frog_control u_frog (
        .i_Clk(i_Clk), .i_rst(i_rst), .i_Game_Active(o_Led_Active), .i_Collided(collided),
        .i_Switches(switches), .o_Frog(frog), .o_Dir(frogDir),
        .o_Score(score), .o_Level_Up(levelUp));

    traffic_lanes u_lanes (
        .i_Clk(i_Clk), .i_rst(i_rst), .i_Frame_Start(frameStart),
        .i_Level_Up(levelUp), .i_Score(score), .o_Cars(cars));

    collision_check u_collide (
        .i_Clk(i_Clk), .i_rst(i_rst), .i_Frog(frog), .i_Cars(cars), .o_Collided(collided));

    scene_renderer u_render (
        .i_Clk(i_Clk), .i_rst(i_rst), .i_Scan(scan), .i_HSync(hSync), .i_VSync(vSync),
        .i_Frog(frog), .i_Dir(frogDir), .i_Cars(cars),
        .o_Pixel(o_VGA_Pixel), .o_HSync(o_VGA_HSync), .o_VSync(o_VGA_VSync));

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:    if (allSwitches) state <= RUNNING;  // All four held starts a run
                RUNNING: if (collided) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_Led_Active = (state == RUNNING);

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
            o_Segments <= 7'b1111110;
        else
        begin
            case (score)
                4'd0:    o_Segments <= 7'b1111110;
                4'd1:    o_Segments <= 7'b0110000;
                4'd2:    o_Segments <= 7'b1101101;
                4'd3:    o_Segments <= 7'b1111001;
                4'd4:    o_Segments <= 7'b0110011;
                4'd5:    o_Segments <= 7'b1011011;
                4'd6:    o_Segments <= 7'b1011111;
                4'd7:    o_Segments <= 7'b1110000;
                4'd8:    o_Segments <= 7'b1111111;
                4'd9:    o_Segments <= 7'b1111011;
                default: o_Segments <= 7'b0000001;  // Dash
            endcase
        end
    end

    // A hit from the collision block ends the run
    assert property (@(posedge i_Clk) disable iff (i_rst)
        (state == RUNNING && collided) |=> state == IDLE)
    else $error("collision did not end the run");

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PeriodNs = 20
) (
    output logic o_Clk
);

    initial
    begin
        o_Clk = 1'b0;
        forever #(PeriodNs / 2) o_Clk = ~o_Clk;
    end

endmodule

`default_nettype wire

// File: sim/frogger_game_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "frogger_consts.svh"

module frogger_game_tb import video_pkg::*; ();

    localparam int DebounceLimit = 4;
    localparam int HLowCycles    = `H_SYNC_PULSE;
    localparam int LineCycles    = `H_TOTAL;
    localparam int VLowCycles    = `V_SYNC_PULSE * `H_TOTAL;
    localparam int FrameCycles   = `V_TOTAL * `H_TOTAL;
    localparam int RunCycleLimit = 3 * FrameCycles;

    logic       i_Clk;
    logic       i_rst;
    logic       i_Switch_Up;
    logic       i_Switch_Left;
    logic       i_Switch_Right;
    logic       i_Switch_Down;
    logic       o_VGA_HSync;
    logic       o_VGA_VSync;
    vga_pixel_t o_VGA_Pixel;
    logic [6:0] o_Segments;
    logic       o_Led_Active;

    int   seed;
    logic expectIdle;
    int   shownDigit;
    int   prevDigit  = 0;
    logic ledPrev    = 1'b0;
    logic ledPrev2   = 1'b0;
    logic hPrev      = 1'b1;
    logic vPrev      = 1'b1;
    logic hFallSeen  = 1'b0;
    int   vFallCount = 0;
    int   hSinceFall = 0;
    int   hLowLen    = 0;
    int   vSinceFall = 0;
    int   vLowLen    = 0;
    int   allHeldRun = 0;
    int   cycleCount = 0;

    tb_clock #(.PeriodNs(20)) u_clock (.o_Clk(i_Clk));

    frogger_game #(.DebounceLimit(DebounceLimit)) DUT (
        .i_Clk(i_Clk), .i_rst(i_rst),
        .i_Switch_Up(i_Switch_Up), .i_Switch_Left(i_Switch_Left),
        .i_Switch_Right(i_Switch_Right), .i_Switch_Down(i_Switch_Down),
        .o_VGA_HSync(o_VGA_HSync), .o_VGA_VSync(o_VGA_VSync), .o_VGA_Pixel(o_VGA_Pixel),
        .o_Segments(o_Segments), .o_Led_Active(o_Led_Active));

    // Segment A in bit 6, G in bit 0
    function automatic int segmentsToDigit(input logic [6:0] seg);
        case (seg)
            7'b1111110: return 0;
            7'b0110000: return 1;
            7'b1101101: return 2;
            7'b1111001: return 3;
            7'b0110011: return 4;
            7'b1011011: return 5;
            7'b1011111: return 6;
            7'b1110000: return 7;
            7'b1111111: return 8;
            7'b1111011: return 9;
            default:    return -1;
        endcase
    endfunction

    task automatic failRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wrongValue(input string name, input int expected, input int actual);
        $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        failRun();
    endtask

    task automatic giveUp(input string reason);
        $display("%s (at %0t)", reason, $time);
        failRun();
    endtask

    task automatic driveAll(input logic level);
        i_Switch_Up    = level;
        i_Switch_Left  = level;
        i_Switch_Right = level;
        i_Switch_Down  = level;
    endtask

    // 0 up, 1 left, 2 right, 3 down
    task automatic pressSwitch(input int which);
        i_Switch_Up    = (which == 0);
        i_Switch_Left  = (which == 1);
        i_Switch_Right = (which == 2);
        i_Switch_Down  = (which == 3);
        repeat (DebounceLimit + 2) @(negedge i_Clk);
        driveAll(1'b0);
        repeat (DebounceLimit + 2) @(negedge i_Clk);
    endtask

    task automatic startRun();
        int waited;
        driveAll(1'b1);
        waited = 0;
        while (!o_Led_Active && waited < DebounceLimit + 8)
        begin
            @(negedge i_Clk);
            waited++;
        end
        if (!o_Led_Active)
            giveUp("Run did not start while all four switches were held");
        else
        begin
            repeat (2) @(negedge i_Clk);
            driveAll(1'b0);
            repeat (DebounceLimit + 2) @(negedge i_Clk);
        end
    endtask

    always_comb shownDigit = segmentsToDigit(o_Segments);

    // Outputs are settled at the falling edge
    always @(negedge i_Clk)
    begin
        cycleCount <= cycleCount + 1;
        prevDigit  <= shownDigit;
        ledPrev    <= o_Led_Active;
        ledPrev2   <= ledPrev;
        hPrev      <= o_VGA_HSync;
        vPrev      <= o_VGA_VSync;
        hSinceFall <= (hPrev && !o_VGA_HSync) ? 1 : hSinceFall + 1;
        vSinceFall <= (vPrev && !o_VGA_VSync) ? 1 : vSinceFall + 1;
        hLowLen    <= o_VGA_HSync ? 0 : hLowLen + 1;
        vLowLen    <= o_VGA_VSync ? 0 : vLowLen + 1;
        if (hPrev && !o_VGA_HSync)
            hFallSeen <= 1'b1;
        if (vPrev && !o_VGA_VSync)
            vFallCount <= vFallCount + 1;
    end

    always @(posedge i_Clk)
    begin
        if (i_Switch_Up && i_Switch_Left && i_Switch_Right && i_Switch_Down)
            allHeldRun <= allHeldRun + 1;
        else
            allHeldRun <= 0;
    end

    assert property (@(negedge i_Clk) disable iff (i_rst)
        $fell(o_VGA_HSync) && hFallSeen |-> hSinceFall == LineCycles)
    else wrongValue("o_VGA_HSync period", LineCycles, $sampled(hSinceFall));

    assert property (@(negedge i_Clk) disable iff (i_rst)
        $rose(o_VGA_HSync) |-> hLowLen == HLowCycles)
    else wrongValue("o_VGA_HSync low cycles", HLowCycles, $sampled(hLowLen));

    assert property (@(negedge i_Clk) disable iff (i_rst)
        $fell(o_VGA_VSync) && vFallCount > 0 |-> vSinceFall == FrameCycles)
    else wrongValue("o_VGA_VSync period", FrameCycles, $sampled(vSinceFall));

    assert property (@(negedge i_Clk) disable iff (i_rst)
        $rose(o_VGA_VSync) |-> vLowLen == VLowCycles)
    else wrongValue("o_VGA_VSync low cycles", VLowCycles, $sampled(vLowLen));

    // Syncs sit inside blanking
    assert property (@(negedge i_Clk) disable iff (i_rst)
        (!o_VGA_HSync || !o_VGA_VSync) |-> o_VGA_Pixel == '0)
    else wrongValue("o_VGA_Pixel", 0, int'($sampled(o_VGA_Pixel)));

    assert property (@(negedge i_Clk) $fell(i_rst) |-> !o_Led_Active)
    else wrongValue("o_Led_Active", 0, $sampled(o_Led_Active));

    assert property (@(negedge i_Clk) $fell(i_rst) |-> shownDigit == 0)
    else wrongValue("o_Segments digit", 0, $sampled(shownDigit));

    assert property (@(negedge i_Clk) disable iff (i_rst) expectIdle |-> !o_Led_Active)
    else wrongValue("o_Led_Active", 0, $sampled(o_Led_Active));

    assert property (@(negedge i_Clk) disable iff (i_rst)
        allHeldRun == DebounceLimit + 2 |-> o_Led_Active)
    else wrongValue("o_Led_Active", 1, $sampled(o_Led_Active));

    assert property (@(negedge i_Clk) disable iff (i_rst) shownDigit >= 0)
    else giveUp($sformatf("Fail at %0t: o_Segments expected a digit pattern, got %b",
                          $time, $sampled(o_Segments)));

    // Score steps by one, or clears as the run ends
    assert property (@(negedge i_Clk) disable iff (i_rst)
        shownDigit != prevDigit |-> shownDigit == prevDigit + 1
            || (shownDigit == 0 && ((ledPrev && !o_Led_Active) || (ledPrev2 && !ledPrev))))
    else wrongValue("o_Segments digit", $sampled(prevDigit) + 1, $sampled(shownDigit));

    initial
    begin
        logic level;
        int   holdCycles;
        int   choice;
        seed       = 22;
        i_rst      = 1'b1;
        expectIdle = 1'b0;
        driveAll(1'b0);
        repeat (10) @(negedge i_Clk);
        i_rst = 1'b0;
        repeat (4) @(negedge i_Clk);

        expectIdle = 1'b1;
        pressSwitch(0);
        pressSwitch(1);
        level = 1'b0;
        repeat (40)
        begin
            level = ~level;
            driveAll(level);
            holdCycles = 1 + ($unsigned($random(seed)) % (DebounceLimit - 1));  // Under the limit
            repeat (holdCycles) @(negedge i_Clk);
        end
        driveAll(1'b0);
        repeat (DebounceLimit + 2) @(negedge i_Clk);
        expectIdle = 1'b0;

        startRun();
        // Mostly up so the frog reaches the goal now and then
        while (vFallCount < 2 && cycleCount < RunCycleLimit)
        begin
            if (!o_Led_Active)
                startRun();
            else
            begin
                choice = $unsigned($random(seed)) % 4;
                pressSwitch(choice < 2 ? 0 : choice - 1);
            end
        end

        if (vFallCount < 2)
            giveUp("Timed out waiting for two vertical sync pulses");
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
verilog/video_pkg.sv
verilog/game_pkg.sv
verilog/debounce_filter.sv
verilog/vga_timing.sv
verilog/frog_control.sv
verilog/traffic_lanes.sv
verilog/collision_check.sv
verilog/scene_renderer.sv
verilog/frogger_game.sv
sim/tb_clock.sv
sim/frogger_game_tb.sv
